/* vdp_ram.f */
+incdir+logic
logic/vdp_ram_pkg.sv
logic/vdp_ram_slot_timer.sv
logic/vdp_ram_vc_arbiter.sv
logic/vdp_ram_slot_seq.sv
logic/vdp_ram.sv
sim/vdp_ram_model.sv
sim/vdp_ram_tb.sv

/* Makefile */
# Verilator build for the video memory access unit testbench

VERILATOR ?= verilator
TOP       ?= vdp_ram_tb
FILELIST  ?= vdp_ram.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/vdp_ram_tb.sv */
//****************************************
// Testbench for the video memory access unit
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "vdp_ram_consts.svh"

module vdp_ram_tb;

    import vdp_ram_pkg::*;

    localparam int N_ROWS     = 14;
    localparam int N_EXTRA    = 6;
    localparam int MAX_CYCLES = (N_ROWS + N_EXTRA) * 64 * `VDP_RAM_SLOT_LEN;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    typedef enum logic { PORT_CPU, PORT_CMD } port_e;

    typedef struct packed {
        port_e                        port;
        logic                         write;
        logic [`VDP_RAM_ADDR_W-1:0]   addr;
        logic [31:0]                  data;
        logic [31:0]                  expected;
    } row_t;

    logic                         CLK;
    logic                         RESET_n;
    cpu_req_t                     cpu;
    logic                         cpu_busy;
    logic [7:0]                   cpu_dout;
    cmd_req_t                     cmd;
    logic                         cmd_busy;
    logic [31:0]                  cmd_dout;
    logic                         disp_req;
    logic [`VDP_RAM_ADDR_W-1:0]   disp_addr;
    logic                         disp_ack;
    logic [31:0]                  disp_dout;
    ram_bus_t                     ram_bus;
    logic [31:0]                  ram_dout;
    logic                         ram_ack_n;
    logic                         vmreq_n;

    row_t         rows [N_ROWS];
    logic [31:0]  lfsr;
    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;
    int           disp_reqs = 0;
    int           disp_acks = 0;
    int           refreshes = 0;
    logic         in_refresh = 1'b0;
    logic         disp_ack_q = 1'b0;
    logic         cpu_busy_q = 1'b0;
    logic         cmd_busy_q = 1'b0;

    vdp_ram vdp_ram_i (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .cpu       (cpu),
        .cpu_busy  (cpu_busy),
        .cpu_dout  (cpu_dout),
        .cmd       (cmd),
        .cmd_busy  (cmd_busy),
        .cmd_dout  (cmd_dout),
        .disp_req  (disp_req),
        .disp_addr (disp_addr),
        .disp_ack  (disp_ack),
        .disp_dout (disp_dout),
        .ram_bus   (ram_bus),
        .ram_dout  (ram_dout),
        .ram_ack_n (ram_ack_n),
        .vmreq_n   (vmreq_n)
    );

    vdp_ram_model ram_model_i (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .ram_bus   (ram_bus),
        .ram_dout  (ram_dout),
        .ram_ack_n (ram_ack_n)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = galois_step(lfsr);
        end
    endtask

    function automatic row_t make_row(input port_e port, input logic write,
                                      input logic [`VDP_RAM_ADDR_W-1:0] addr,
                                      input logic [31:0] data, input logic [31:0] expected);
        return '{port, write, addr, data, expected};
    endfunction

    task automatic build_table;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] c;
        draw_bits(8, a);
        draw_bits(32, w);
        draw_bits(32, c);
        // CPU bytes written then read back
        rows[0]  = make_row(PORT_CPU, 1'b1, 19'h00010, 32'h5a, 32'h0);
        rows[1]  = make_row(PORT_CPU, 1'b1, 19'h00011, a, 32'h0);
        rows[2]  = make_row(PORT_CPU, 1'b0, 19'h00010, 32'h0, 32'h5a);
        rows[3]  = make_row(PORT_CPU, 1'b0, 19'h00011, 32'h0, {24'h0, a[7:0]});
        // Command word read back as four little-endian CPU bytes
        rows[4]  = make_row(PORT_CMD, 1'b1, 19'h00100, w, 32'h0);
        rows[5]  = make_row(PORT_CPU, 1'b0, 19'h00100, 32'h0, {24'h0, w[7:0]});
        rows[6]  = make_row(PORT_CPU, 1'b0, 19'h00101, 32'h0, {24'h0, w[15:8]});
        rows[7]  = make_row(PORT_CPU, 1'b0, 19'h00102, 32'h0, {24'h0, w[23:16]});
        rows[8]  = make_row(PORT_CPU, 1'b0, 19'h00103, 32'h0, {24'h0, w[31:24]});
        // CPU bytes assembled into a command word
        rows[9]  = make_row(PORT_CPU, 1'b1, 19'h00200, {24'h0, c[7:0]}, 32'h0);
        rows[10] = make_row(PORT_CPU, 1'b1, 19'h00201, {24'h0, c[15:8]}, 32'h0);
        rows[11] = make_row(PORT_CPU, 1'b1, 19'h00202, {24'h0, c[23:16]}, 32'h0);
        rows[12] = make_row(PORT_CPU, 1'b1, 19'h00203, {24'h0, c[31:24]}, 32'h0);
        rows[13] = make_row(PORT_CMD, 1'b0, 19'h00200, 32'h0, c);
    endtask

    // Strobe stays low until busy rises and the result is valid once busy falls
    task automatic host_access(input port_e port, input logic write,
                               input logic [`VDP_RAM_ADDR_W-1:0] addr, input logic [31:0] data,
                               output logic [31:0] dout, output time busy_at);
        @(negedge CLK);
        if (port == PORT_CPU) begin
            cpu = '{oe_n: write, we_n: !write, addr: addr, din: data[7:0]};
        end else begin
            cmd = '{oe_n: write, we_n: !write, addr: addr, din: data};
        end
        @(negedge CLK);
        while (!(port == PORT_CPU ? cpu_busy : cmd_busy)) begin
            @(negedge CLK);
        end
        busy_at = $time;
        if (port == PORT_CPU) begin
            cpu.oe_n = 1'b1;
            cpu.we_n = 1'b1;
        end else begin
            cmd.oe_n = 1'b1;
            cmd.we_n = 1'b1;
        end
        while (port == PORT_CPU ? cpu_busy : cmd_busy) begin
            @(negedge CLK);
        end
        dout = (port == PORT_CPU) ? {24'h0, cpu_dout} : cmd_dout;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("at %0t %s", $time, what);
        end
    endtask

    // Bus rules that hold in every cycle
    always @(negedge CLK) begin
        if (RESET_n) begin
            if (!ram_bus.oe_n || !ram_bus.we_n || !ram_bus.rfsh_n) begin
                expect_true(!vmreq_n, "a RAM strobe is active while vmreq_n is high");
            end
            // A refresh window runs until the next read or write starts
            if (!ram_bus.rfsh_n) begin
                expect_true(ram_bus.oe_n && ram_bus.we_n, "refresh overlaps a read or write");
                if (!in_refresh) begin
                    refreshes++;
                end
                in_refresh = 1'b1;
            end else if (!ram_bus.oe_n || !ram_bus.we_n) begin
                in_refresh = 1'b0;
            end
            if (in_refresh) begin
                expect_true(!disp_ack && !(cpu_busy_q && !cpu_busy) &&
                            !(cmd_busy_q && !cmd_busy), "an acknowledge came during refresh");
            end
            if (disp_req) begin
                disp_reqs++;
                expect_true(vmreq_n, "vmreq_n is low at the start of a display slot");
            end
            if (disp_ack) begin
                disp_acks++;
                expect_true(!disp_ack_q, "disp_ack lasted longer than one cycle");
            end
            disp_ack_q = disp_ack;
            cpu_busy_q = cpu_busy;
            cmd_busy_q = cmd_busy;
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        logic [31:0] dout;
        logic [31:0] dout2;
        logic [31:0] cpu_byte;
        logic [31:0] cmd_word;
        time         cpu_t;
        time         cmd_t;
        RESET_n   = 1'b0;
        cpu       = '{oe_n: 1'b1, we_n: 1'b1, addr: '0, din: '0};
        cmd       = '{oe_n: 1'b1, we_n: 1'b1, addr: '0, din: '0};
        disp_addr = 19'h00100;
        lfsr      = 32'd95033;
        build_table();
        draw_bits(8, cpu_byte);
        draw_bits(32, cmd_word);
        repeat (4) @(negedge CLK);
        RESET_n = 1'b1;

        for (int i = 0; i < N_ROWS; i++) begin
            host_access(rows[i].port, rows[i].write, rows[i].addr, rows[i].data, dout, cpu_t);
            if (!rows[i].write) begin
                check_value(rows[i].port == PORT_CPU ? "cpu_dout" : "cmd_dout", dout,
                            rows[i].expected);
            end
        end

        // Both host ports strobe on the same falling edge and the CPU goes first
        fork
            host_access(PORT_CPU, 1'b1, 19'h00300, cpu_byte, dout, cpu_t);
            host_access(PORT_CMD, 1'b1, 19'h00304, cmd_word, dout2, cmd_t);
        join
        expect_true(cpu_t < cmd_t, "cpu_busy did not rise before cmd_busy on writes");
        fork
            host_access(PORT_CPU, 1'b0, 19'h00300, 32'h0, dout, cpu_t);
            host_access(PORT_CMD, 1'b0, 19'h00304, 32'h0, dout2, cmd_t);
        join
        expect_true(cpu_t < cmd_t, "cpu_busy did not rise before cmd_busy on reads");
        check_value("cpu_dout", dout, {24'h0, cpu_byte[7:0]});
        check_value("cmd_dout", dout2, cmd_word);

        // Display reads follow disp_addr
        @(negedge CLK);
        while (!disp_ack) begin
            @(negedge CLK);
        end
        check_value("disp_dout", disp_dout, rows[4].data);
        disp_addr = 19'h00304;
        @(negedge CLK);
        while (!disp_ack) begin
            @(negedge CLK);
        end
        check_value("disp_dout", disp_dout, cmd_word);

        // Bus monitor has finished this falling edge by the next rising one
        @(posedge CLK);
        expect_true(refreshes > 0, "no refresh cycle was seen");
        expect_true(disp_acks <= disp_reqs && disp_acks + 1 >= disp_reqs,
                    "display acknowledges do not match display slots");
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/vdp_ram_model.sv */
//****************************************
// Behavioral RAM with two-phase acknowledge
// 4 KB byte array, addresses wrap
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "vdp_ram_consts.svh"

module vdp_ram_model (
    input  wire                            CLK,
    input  wire                            RESET_n,
    input  vdp_ram_pkg::ram_bus_t          ram_bus,
    output logic [`VDP_RAM_DATA_W-1:0]     ram_dout,
    output logic                           ram_ack_n
);

    import vdp_ram_pkg::*;

    localparam int DEPTH   = 4096;
    localparam int ACK_LOW = 3;
    localparam int ACK_END = ACK_LOW + 2;

    logic [7:0]   mem [DEPTH];
    logic [11:0]  base;
    logic         strobe;
    logic         busy;
    int           cnt;

    assign base   = ram_bus.addr[11:0];
    assign strobe = !ram_bus.oe_n || !ram_bus.we_n || !ram_bus.rfsh_n;

    always @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            // Fill depends on every address bit
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= 8'(i) ^ 8'(i >> 4) ^ 8'h5a;
            end
            busy      <= 1'b0;
            cnt       <= 0;
            ram_ack_n <= 1'b1;
            ram_dout  <= '0;
        end else if (!busy) begin
            if (strobe) begin
                busy <= 1'b1;
                cnt  <= 1;
                if (!ram_bus.we_n) begin
                    mem[base] <= ram_bus.din.lane[0];
                end
                // Word writes store the remaining lanes little-endian
                if (!ram_bus.we_n && ram_bus.din_size == `VDP_RAM_SIZE_WORD) begin
                    mem[base + 12'd1] <= ram_bus.din.lane[1];
                    mem[base + 12'd2] <= ram_bus.din.lane[2];
                    mem[base + 12'd3] <= ram_bus.din.lane[3];
                end
                if (!ram_bus.oe_n) begin
                    ram_dout <= {mem[base + 12'd3], mem[base + 12'd2],
                                 mem[base + 12'd1], mem[base]};
                end
            end
        end else begin
            cnt <= cnt + 1;
            if (cnt == ACK_LOW) begin
                ram_ack_n <= 1'b0;
            end
            if (cnt == ACK_END) begin
                ram_ack_n <= 1'b1;
                busy      <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/vdp_ram.sv */
//****************************************
// Video memory access unit
// Shares one RAM among CPU, command, display
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "vdp_ram_consts.svh"

module vdp_ram (
    input  wire                            CLK,
    input  wire                            RESET_n,
    input  vdp_ram_pkg::cpu_req_t          cpu,
    output logic                           cpu_busy,
    output logic [7:0]                     cpu_dout,
    input  vdp_ram_pkg::cmd_req_t          cmd,
    output logic                           cmd_busy,
    output logic [`VDP_RAM_DATA_W-1:0]     cmd_dout,
    output logic                           disp_req,
    input  logic [`VDP_RAM_ADDR_W-1:0]     disp_addr,
    output logic                           disp_ack,
    output logic [`VDP_RAM_DATA_W-1:0]     disp_dout,
    output vdp_ram_pkg::ram_bus_t          ram_bus,
    input  logic [`VDP_RAM_DATA_W-1:0]     ram_dout,
    input  logic                           ram_ack_n,
    output logic                           vmreq_n
);

    import vdp_ram_pkg::*;

    slot_e       slot;
    logic        prep;
    logic        exec;
    logic        vc_slot;
    vc_req_t     vc_req;
    logic        vc_ack;
    ram_word_u   vc_dout;

    vdp_ram_slot_timer slot_timer_i (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .slot    (slot),
        .prep    (prep),
        .exec    (exec)
    );

    vdp_ram_vc_arbiter vc_arbiter_i (
        .CLK      (CLK),
        .RESET_n  (RESET_n),
        .vc_slot  (vc_slot),
        .cpu      (cpu),
        .cpu_busy (cpu_busy),
        .cpu_dout (cpu_dout),
        .cmd      (cmd),
        .cmd_busy (cmd_busy),
        .cmd_dout (cmd_dout),
        .vc_req   (vc_req),
        .vc_ack   (vc_ack),
        .vc_dout  (vc_dout)
    );

    vdp_ram_slot_seq slot_seq_i (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .slot      (slot),
        .prep      (prep),
        .exec      (exec),
        .vc_slot   (vc_slot),
        .vc_req    (vc_req),
        .vc_ack    (vc_ack),
        .vc_dout   (vc_dout),
        .disp_req  (disp_req),
        .disp_addr (disp_addr),
        .disp_ack  (disp_ack),
        .disp_dout (disp_dout),
        .ram_bus   (ram_bus),
        .ram_dout  (ram_dout),
        .ram_ack_n (ram_ack_n),
        .vmreq_n   (vmreq_n)
    );

endmodule

`default_nettype wire

/* logic/vdp_ram_slot_seq.sv */
//****************************************
// RAM slot sequencer
// Runs one RAM cycle per slot and returns data
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "vdp_ram_consts.svh"

module vdp_ram_slot_seq (
    input  wire                            CLK,
    input  wire                            RESET_n,
    input  vdp_ram_pkg::slot_e             slot,
    input  logic                           prep,
    input  logic                           exec,
    output logic                           vc_slot,
    input  vdp_ram_pkg::vc_req_t           vc_req,
    output logic                           vc_ack,
    output vdp_ram_pkg::ram_word_u         vc_dout,
    output logic                           disp_req,
    input  logic [`VDP_RAM_ADDR_W-1:0]     disp_addr,
    output logic                           disp_ack,
    output logic [`VDP_RAM_DATA_W-1:0]     disp_dout,
    output vdp_ram_pkg::ram_bus_t          ram_bus,
    input  logic [`VDP_RAM_DATA_W-1:0]     ram_dout,
    input  logic                           ram_ack_n,
    output logic                           vmreq_n
);

    import vdp_ram_pkg::*;

    typedef enum logic [1:0] {
        ST_WAIT_REQ,
        ST_WAIT_ACK,
        ST_WAIT_RELEASE
    } state_e;

    // One-hot acknowledge owner, refresh has no bit
    localparam int ACK_VC   = 0;
    localparam int ACK_DISP = 1;

    state_e                       state;
    slot_e                        owner;
    logic [1:0]                   ack_own;

    logic                         bus_oe_n;
    logic                         bus_we_n;
    logic                         bus_rfsh_n;
    logic [`VDP_RAM_ADDR_W-1:0]   bus_addr;
    ram_word_u                    bus_din;
    logic [1:0]                   bus_size;

    logic                         vc_idle;
    logic                         start;
    logic                         release_done;

    // Slot announcements toward the requesters
    assign vc_slot  = prep && (slot == SLOT_VC);
    assign disp_req = prep && (slot == SLOT_DISP);

    assign vc_idle      = vc_req.oe_n && vc_req.we_n;
    assign start        = (state == ST_WAIT_REQ) && exec;
    assign release_done = (state == ST_WAIT_RELEASE) && ram_ack_n;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            owner <= SLOT_NONE;
        end else if (prep) begin
            owner <= slot;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state      <= ST_WAIT_REQ;
            ack_own    <= 2'b00;
            bus_oe_n   <= 1'b1;
            bus_we_n   <= 1'b1;
            bus_rfsh_n <= 1'b1;
            vc_ack     <= 1'b0;
            disp_ack   <= 1'b0;
            vmreq_n    <= 1'b1;
        end else begin
            vc_ack   <= 1'b0;
            disp_ack <= 1'b0;
            case (state)
                ST_WAIT_REQ: begin
                    if (start && owner == SLOT_VC && !vc_idle) begin
                        state    <= ST_WAIT_ACK;
                        ack_own  <= 2'b01 << ACK_VC;
                        bus_oe_n <= vc_req.oe_n;
                        bus_we_n <= vc_req.we_n;
                        vmreq_n  <= 1'b0;
                    end else if (start && owner == SLOT_DISP) begin
                        state    <= ST_WAIT_ACK;
                        ack_own  <= 2'b01 << ACK_DISP;
                        bus_oe_n <= 1'b0;
                        vmreq_n  <= 1'b0;
                    end else if (start && owner == SLOT_REFRESH) begin
                        state      <= ST_WAIT_ACK;
                        ack_own    <= 2'b00;
                        bus_rfsh_n <= 1'b0;
                        vmreq_n    <= 1'b0;
                    end
                end
                ST_WAIT_ACK: begin
                    // RAM has taken the cycle
                    if (!ram_ack_n) begin
                        state      <= ST_WAIT_RELEASE;
                        bus_oe_n   <= 1'b1;
                        bus_we_n   <= 1'b1;
                        bus_rfsh_n <= 1'b1;
                    end
                end
                default: begin
                    if (ram_ack_n) begin
                        state    <= ST_WAIT_REQ;
                        ack_own  <= 2'b00;
                        vc_ack   <= ack_own[ACK_VC];
                        disp_ack <= ack_own[ACK_DISP];
                        vmreq_n  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Address and data path
    always_ff @(posedge CLK) begin
        if (start && owner == SLOT_VC) begin
            bus_addr <= vc_req.addr;
            bus_din  <= vc_req.din;
            bus_size <= vc_req.din_size;
        end else if (start && owner == SLOT_DISP) begin
            bus_addr <= disp_addr;
            bus_size <= `VDP_RAM_SIZE_WORD;
        end
        if (release_done && ack_own[ACK_VC]) begin
            vc_dout.word <= ram_dout;
        end
        if (release_done && ack_own[ACK_DISP]) begin
            disp_dout <= ram_dout;
        end
    end

    assign ram_bus = '{
        oe_n:     bus_oe_n,
        we_n:     bus_we_n,
        rfsh_n:   bus_rfsh_n,
        addr:     bus_addr,
        din:      bus_din,
        din_size: bus_size
    };

endmodule

`default_nettype wire

/* logic/vdp_ram_vc_arbiter.sv */
//****************************************
// CPU and command arbiter for the VC slot
// CPU wins when both ports are pending
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "vdp_ram_consts.svh"

module vdp_ram_vc_arbiter (
    input  wire                            CLK,
    input  wire                            RESET_n,
    input  logic                           vc_slot,
    input  vdp_ram_pkg::cpu_req_t          cpu,
    output logic                           cpu_busy,
    output logic [7:0]                     cpu_dout,
    input  vdp_ram_pkg::cmd_req_t          cmd,
    output logic                           cmd_busy,
    output logic [`VDP_RAM_DATA_W-1:0]     cmd_dout,
    output vdp_ram_pkg::vc_req_t           vc_req,
    input  logic                           vc_ack,
    input  vdp_ram_pkg::ram_word_u         vc_dout
);

    import vdp_ram_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_WAIT_ACK
    } state_e;

    typedef enum logic {
        SEL_CPU,
        SEL_CMD
    } select_e;

    state_e                       state;
    select_e                      sel;

    logic                         vc_oe_n;
    logic                         vc_we_n;
    logic [`VDP_RAM_ADDR_W-1:0]   vc_addr;
    ram_word_u                    vc_din;
    logic [1:0]                   vc_size;

    logic                         cpu_pending;
    logic                         cmd_pending;
    logic                         grant;
    logic                         done;

    assign cpu_pending = !cpu.oe_n || !cpu.we_n;
    assign cmd_pending = !cmd.oe_n || !cmd.we_n;
    assign grant       = (state == ST_IDLE) && vc_slot;
    assign done        = (state == ST_WAIT_ACK) && vc_ack;

    // Strobes, busy flags and state
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state    <= ST_IDLE;
            sel      <= SEL_CPU;
            vc_oe_n  <= 1'b1;
            vc_we_n  <= 1'b1;
            cpu_busy <= 1'b0;
            cmd_busy <= 1'b0;
        end else if (grant && cpu_pending) begin
            state    <= ST_WAIT_ACK;
            sel      <= SEL_CPU;
            vc_oe_n  <= cpu.oe_n;
            vc_we_n  <= cpu.we_n;
            cpu_busy <= 1'b1;
        end else if (grant && cmd_pending) begin
            state    <= ST_WAIT_ACK;
            sel      <= SEL_CMD;
            vc_oe_n  <= cmd.oe_n;
            vc_we_n  <= cmd.we_n;
            cmd_busy <= 1'b1;
        end else if (done) begin
            state   <= ST_IDLE;
            vc_oe_n <= 1'b1;
            vc_we_n <= 1'b1;
            // Only the requester that was served goes idle
            if (sel == SEL_CPU) begin
                cpu_busy <= 1'b0;
            end else begin
                cmd_busy <= 1'b0;
            end
        end
    end

    // Address, write data and read data
    always_ff @(posedge CLK) begin
        if (grant && cpu_pending) begin
            vc_addr     <= cpu.addr;
            vc_din.lane <= {4{cpu.din}};
            vc_size     <= `VDP_RAM_SIZE_BYTE;
        end else if (grant && cmd_pending) begin
            vc_addr     <= cmd.addr;
            vc_din.word <= cmd.din;
            vc_size     <= `VDP_RAM_SIZE_WORD;
        end
        if (done && sel == SEL_CPU) begin
            cpu_dout <= vc_dout.lane[0];
        end
        if (done && sel == SEL_CMD) begin
            cmd_dout <= vc_dout.word;
        end
    end

    assign vc_req = '{
        oe_n:     vc_oe_n,
        we_n:     vc_we_n,
        addr:     vc_addr,
        din:      vc_din,
        din_size: vc_size
    };

endmodule

`default_nettype wire

/* logic/vdp_ram_slot_timer.sv */
//****************************************
// Slot timer for the video memory unit
// Rotates vc, disp, vc, refresh slots
//****************************************

`timescale 1ns/1ps
`default_nettype none

`include "vdp_ram_consts.svh"

module vdp_ram_slot_timer (
    input  wire                  CLK,
    input  wire                  RESET_n,
    output vdp_ram_pkg::slot_e   slot,
    output logic                 prep,
    output logic                 exec
);

    import vdp_ram_pkg::*;

    localparam int CNT_W = $clog2(`VDP_RAM_SLOT_LEN);

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`VDP_RAM_SLOT_LEN - 1);
    localparam logic [CNT_W-1:0] CNT_PREP = CNT_W'(`VDP_RAM_PREP_AT);
    localparam logic [CNT_W-1:0] CNT_EXEC = CNT_W'(`VDP_RAM_EXEC_AT);

    // Cycle within the slot
    logic [CNT_W-1:0] count;

    // Position in the four-slot rotation
    logic [1:0]       slot_idx;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            count    <= '0;
            slot_idx <= 2'd0;
        end else begin
            if (count == CNT_LAST) begin
                count    <= '0;
                slot_idx <= slot_idx + 2'd1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Host side gets every other slot, display and refresh share the rest
    always_comb begin
        case (slot_idx)
            2'd0:    slot = SLOT_VC;
            2'd1:    slot = SLOT_DISP;
            2'd2:    slot = SLOT_VC;
            default: slot = SLOT_REFRESH;
        endcase
    end

    // Prep lets the owner get ready, exec starts the RAM cycle
    assign prep = (count == CNT_PREP);
    assign exec = (count == CNT_EXEC);

endmodule

`default_nettype wire

/* logic/vdp_ram_pkg.sv */
//****************************************
// Types shared by the video memory unit
//****************************************

`default_nettype none

`include "vdp_ram_consts.svh"

package vdp_ram_pkg;

    // Owner of the current access slot
    typedef enum logic [1:0] {
        SLOT_NONE    = 2'd0,
        SLOT_VC      = 2'd1,
        SLOT_DISP    = 2'd2,
        SLOT_REFRESH = 2'd3
    } slot_e;

    // CPU byte port request
    typedef struct packed {
        logic                         oe_n;
        logic                         we_n;
        logic [`VDP_RAM_ADDR_W-1:0]   addr;
        logic [7:0]                   din;
    } cpu_req_t;

    // Drawing command word port request
    typedef struct packed {
        logic                         oe_n;
        logic                         we_n;
        logic [`VDP_RAM_ADDR_W-1:0]   addr;
        logic [`VDP_RAM_DATA_W-1:0]   din;
    } cmd_req_t;

    // RAM data seen as one word or as four byte lanes
    typedef union packed {
        logic [`VDP_RAM_DATA_W-1:0]   word;
        logic [3:0][7:0]              lane;
    } ram_word_u;

    // Merged CPU/command request for the VC slot
    typedef struct packed {
        logic                         oe_n;
        logic                         we_n;
        logic [`VDP_RAM_ADDR_W-1:0]   addr;
        ram_word_u                    din;
        logic [1:0]                   din_size;
    } vc_req_t;

    // Outputs toward the external RAM
    typedef struct packed {
        logic                         oe_n;
        logic                         we_n;
        logic                         rfsh_n;
        logic [`VDP_RAM_ADDR_W-1:0]   addr;
        ram_word_u                    din;
        logic [1:0]                   din_size;
    } ram_bus_t;

endpackage

`default_nettype wire

/* logic/vdp_ram_consts.svh */
//****************************************
// Video memory access unit constants
// Bus widths, slot timing and size codes
//****************************************

`ifndef VDP_RAM_CONSTS_SVH
`define VDP_RAM_CONSTS_SVH

// RAM byte address and data widths
`define VDP_RAM_ADDR_W      19
`define VDP_RAM_DATA_W      32

// Clock cycles in one access slot
`define VDP_RAM_SLOT_LEN    16

// Cycles within a slot where prep and exec pulse
`define VDP_RAM_PREP_AT     0
`define VDP_RAM_EXEC_AT     2

// Access size codes carried with the write data
`define VDP_RAM_SIZE_BYTE   2'd0
`define VDP_RAM_SIZE_WORD   2'd2

`endif
